// File: design/av_config_pkg.sv
////////////////////////////////////////////////////////////
// Frame layout, host register map and codec settings.
// Bus timing assumes QUARTER_CYCLES of 4 (16 clocks per bit).
// Auto-init entry i programs codec register i, i below INIT_COUNT
////////////////////////////////////////////////////////////
`default_nettype none

package av_config_pkg;

	// Three bytes, each followed by an ack slot
	localparam int FRAME_W = 27;

	// One serial frame, read as codec or as video decoder frame
	typedef union packed {
		struct packed {
			logic [7:0] dev_addr;
			logic       ack0;
			logic [6:0] reg_addr;
			logic       data_hi;
			logic       ack1;
			logic [7:0] data_lo;
			logic       ack2;
		} codec;
		struct packed {
			logic [7:0] dev_addr;
			logic       ack0;
			logic [7:0] reg_addr;
			// Marker that sits in the second ack slot
			logic       read_flag;
			logic [7:0] data;
			logic       ack2;
		} video;
	} av_frame_u;

	// 1 marks a slot the master releases and samples
	localparam logic [FRAME_W-1:0] WRITE_MASK = {8'h00, 1'b1, 8'h00, 1'b1, 8'h00, 1'b1};
	// Read frame receives one byte, then the master drives its own nack
	localparam logic [FRAME_W-1:0] READ_MASK = {8'h00, 1'b1, 8'hFF, 1'b0, 8'h00, 1'b0};

	localparam logic [7:0] AUDIO_DEV_ADDR    = 8'h34;
	localparam logic [7:0] VIDEO_DEV_WR_ADDR = 8'h40;
	localparam logic [7:0] VIDEO_DEV_RD_ADDR = 8'h41;

	// Host register indices
	localparam logic [1:0] REG_CONTROL = 2'd0;
	localparam logic [1:0] REG_STATUS  = 2'd1;
	localparam logic [1:0] REG_ADDRESS = 2'd2;
	localparam logic [1:0] REG_DATA    = 2'd3;

	localparam logic [7:0] CFG_TYPE = 8'h03;

	localparam int QUARTER_CYCLES = 4;
	localparam int INIT_COUNT     = 10;
	localparam int INIT_IDX_W     = 4;

	// Codec power-up values
	localparam logic [8:0] AUD_LINE_IN_LC  = 9'h01A;
	localparam logic [8:0] AUD_LINE_IN_RC  = 9'h01A;
	localparam logic [8:0] AUD_LINE_OUT_LC = 9'h07B;
	localparam logic [8:0] AUD_LINE_OUT_RC = 9'h07B;
	localparam logic [8:0] AUD_ADC_PATH    = 9'd146;
	localparam logic [8:0] AUD_DAC_PATH    = 9'h006;
	localparam logic [8:0] AUD_POWER       = 9'h000;
	localparam logic [8:0] AUD_DATA_FORMAT = 9'd73;
	localparam logic [8:0] AUD_SAMPLE_CTRL = 9'd0;
	localparam logic [8:0] AUD_SET_ACTIVE  = 9'h001;

	// Host side transfer FSM
	localparam logic [2:0] ST_IDLE           = 3'd0;
	localparam logic [2:0] ST_PRE_WRITE      = 3'd1;
	localparam logic [2:0] ST_WRITE_TRANSFER = 3'd2;
	localparam logic [2:0] ST_POST_WRITE     = 3'd3;
	localparam logic [2:0] ST_PRE_READ       = 3'd4;
	localparam logic [2:0] ST_READ_TRANSFER  = 3'd5;
	localparam logic [2:0] ST_POST_READ      = 3'd6;

	// Serial bus controller phases
	localparam logic [2:0] SB_IDLE    = 3'd0;
	localparam logic [2:0] SB_START   = 3'd1;
	localparam logic [2:0] SB_BITS    = 3'd2;
	localparam logic [2:0] SB_RESTART = 3'd3;
	localparam logic [2:0] SB_STOP    = 3'd4;

endpackage

`default_nettype wire

// File: design/av_config_init_rom.sv
////////////////////////////////////////////////////////////
// Codec power-up table, purely combinational.
// Indices past INIT_COUNT give an all-zero frame
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module av_config_init_rom (
	input  logic [av_config_pkg::INIT_IDX_W-1:0] rom_index,
	output av_config_pkg::av_frame_u             rom_frame
);
	import av_config_pkg::*;

	logic [8:0] setting;

	always_comb
	begin
		case (rom_index)
			4'd0:    setting = AUD_LINE_IN_LC;
			4'd1:    setting = AUD_LINE_IN_RC;
			4'd2:    setting = AUD_LINE_OUT_LC;
			4'd3:    setting = AUD_LINE_OUT_RC;
			4'd4:    setting = AUD_ADC_PATH;
			4'd5:    setting = AUD_DAC_PATH;
			4'd6:    setting = AUD_POWER;
			4'd7:    setting = AUD_DATA_FORMAT;
			4'd8:    setting = AUD_SAMPLE_CTRL;
			// Activate last, once the rest is set
			4'd9:    setting = AUD_SET_ACTIVE;
			default: setting = '0;
		endcase
		rom_frame = '0;
		if (rom_index < INIT_IDX_W'(INIT_COUNT))
		begin
			rom_frame.codec.dev_addr = AUDIO_DEV_ADDR;
			rom_frame.codec.reg_addr = 7'(rom_index);
			rom_frame.codec.data_hi  = setting[8];
			rom_frame.codec.data_lo  = setting[7:0];
		end
	end

endmodule

`default_nettype wire

// File: design/av_config_auto_init.sv
////////////////////////////////////////////////////////////
// Sends the codec table once after reset. A nack on any
// entry is kept in init_error until the next reset
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module av_config_auto_init (
	input  logic                                   clk,
	input  logic                                   internal_reset,
	input  logic                                   transfer_complete,
	input  logic                                   nack,
	input  av_config_pkg::av_frame_u               rom_frame,
	output logic [av_config_pkg::INIT_IDX_W-1:0]   rom_index,
	output av_config_pkg::av_frame_u               init_frame,
	output logic                                   init_start,
	output logic                                   init_done,
	output logic                                   init_error
);
	import av_config_pkg::*;

	logic first;
	logic last_entry;

	assign last_entry = (rom_index == INIT_IDX_W'(INIT_COUNT - 1));
	assign init_frame = rom_frame;

	always_ff @(posedge clk)
	begin
		if (internal_reset)
		begin
			first      <= 1'b1;
			rom_index  <= '0;
			init_start <= 1'b0;
			init_done  <= 1'b0;
			init_error <= 1'b0;
		end
		else
		begin
			first      <= 1'b0;
			// Entry 0 right after reset, then one per completion
			init_start <= first || (transfer_complete && !init_done && !last_entry);
			if (transfer_complete && !init_done)
			begin
				init_error <= init_error || nack;
				if (last_entry)
					init_done <= 1'b1;
				else
					rom_index <= rom_index + 1'b1;
			end
		end
	end

	// Index steps once per completion, so a completion lasts one cycle
	single_complete: assert property (@(posedge clk) disable iff (internal_reset)
		transfer_complete |=> !transfer_complete);

endmodule

`default_nettype wire

// File: design/serial_bus_controller.sv
////////////////////////////////////////////////////////////
// Two-wire bus master, one 27-bit frame plus an optional read
// frame after a repeated start. No clock stretching and no
// arbitration; start is ignored while busy
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module serial_bus_controller (
	input  logic                     clk,
	input  logic                     internal_reset,
	input  logic                     start_transfer,
	input  logic                     read_transfer,
	input  av_config_pkg::av_frame_u frame,
	input  av_config_pkg::av_frame_u restart_frame,
	output logic                     busy,
	output logic                     transfer_complete,
	output logic                     scl,
	output logic                     sda_drive_low,
	input  logic                     sda_in,
	output logic [7:0]               rx_data,
	output logic                     nack
);
	import av_config_pkg::*;

	logic [2:0]         state;
	logic [1:0]         div;
	logic [1:0]         phase;
	logic [4:0]         bit_idx;
	logic [FRAME_W-1:0] cur_frame;
	logic [FRAME_W-1:0] cur_mask;
	logic [FRAME_W-1:0] restart_q;
	logic               read_q;
	logic               second;
	logic               drive_q;
	logic               drive_bit;
	logic               qtick;
	logic               late_half;

	assign busy = (state != SB_IDLE);
	assign qtick = (div == 2'(QUARTER_CYCLES - 1));
	assign late_half = (div >= 2'(QUARTER_CYCLES / 2));
	// Masked slots are released whatever the frame holds
	assign drive_bit = !cur_mask[bit_idx] && !cur_frame[bit_idx];

	// Bit quarters: scl low, low (data set), high (sample), high
	always_comb
	begin
		case (state)
			SB_START:   {scl, sda_drive_low} = {1'b1, phase == 2'd1};
			SB_BITS:    {scl, sda_drive_low} = {phase[1], phase == 2'd0 ? drive_q : drive_bit};
			// Line goes low halfway through the high quarter
			SB_RESTART: {scl, sda_drive_low} = {phase[0], phase == 2'd1 && late_half};
			SB_STOP:    {scl, sda_drive_low} = {phase[0], phase == 2'd1 || late_half};
			default:    {scl, sda_drive_low} = 2'b10;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (internal_reset)
		begin
			state             <= SB_IDLE;
			div               <= '0;
			phase             <= '0;
			transfer_complete <= 1'b0;
			nack              <= 1'b0;
		end
		else
		begin
			transfer_complete <= 1'b0;
			if (state == SB_IDLE)
			begin
				div   <= '0;
				phase <= '0;
				if (start_transfer)
				begin
					state     <= SB_START;
					cur_frame <= frame;
					cur_mask  <= WRITE_MASK;
					restart_q <= restart_frame;
					read_q    <= read_transfer;
					second    <= 1'b0;
					nack      <= 1'b0;
				end
			end
			else
			begin
				div <= qtick ? 2'd0 : div + 2'd1;
				if (qtick)
				begin
					phase <= phase + 2'd1;
					case (state)
						SB_START, SB_RESTART:
						begin
							if (phase == 2'd1)
							begin
								state   <= SB_BITS;
								phase   <= '0;
								bit_idx <= 5'(FRAME_W - 1);
								drive_q <= 1'b1;
								// Second pass shifts the read frame
								if (state == SB_RESTART)
								begin
									cur_frame <= restart_q;
									cur_mask  <= READ_MASK;
									second    <= 1'b1;
								end
							end
						end
						SB_BITS:
						begin
							// Sample in the middle of scl high
							if (phase == 2'd2 && cur_mask[bit_idx])
							begin
								if (WRITE_MASK[bit_idx])
									nack <= nack || sda_in;
								else
									rx_data <= {rx_data[6:0], sda_in};
							end
							if (phase == 2'd3)
							begin
								drive_q <= drive_bit;
								if (bit_idx != 5'd0)
									bit_idx <= bit_idx - 5'd1;
								else if (read_q && !second)
									state <= SB_RESTART;
								else
									state <= SB_STOP;
							end
						end
						default:
						begin
							if (phase == 2'd1)
							begin
								state             <= SB_IDLE;
								transfer_complete <= 1'b1;
							end
						end
					endcase
				end
			end
		end
	end

	// Data moves only under scl low, apart from start, restart and stop edges
	sda_stable_high: assert property (@(posedge clk) disable iff (internal_reset)
		$changed(sda_drive_low) |-> (!scl && !$past(scl))
			|| state == SB_START || state == SB_RESTART || $past(state) == SB_STOP);

endmodule

`default_nettype wire

// File: design/av_config_regs.sv
////////////////////////////////////////////////////////////
// Host registers. Only the data port stalls; one serial
// transfer at a time, accesses to data wait while it runs
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module av_config_regs (
	input  logic                     clk,
	input  logic                     internal_reset,
	input  logic [1:0]               address,
	input  logic [3:0]               byteenable,
	input  logic                     read,
	input  logic                     write,
	input  logic [31:0]              writedata,
	output logic [31:0]              readdata,
	output logic                     waitrequest,
	input  logic                     init_done,
	input  logic                     init_error,
	input  logic                     busy,
	input  logic                     transfer_complete,
	input  logic                     nack,
	input  logic [7:0]               rx_data,
	output logic                     start_transfer,
	output logic                     read_transfer,
	output av_config_pkg::av_frame_u frame,
	output av_config_pkg::av_frame_u restart_frame,
	output logic                     irq
);
	import av_config_pkg::*;

	logic        irq_en;
	logic        dev_sel;
	logic [7:0]  address_reg;
	logic [31:0] data_reg;
	logic [2:0]  state;
	logic [2:0]  state_nx;
	logic        xfer_dev;
	logic [7:0]  xfer_addr;
	logic        data_access;
	logic        host_wr;
	logic        launch;

	assign data_access = (address == REG_DATA) && (read || write);
	// Data accesses complete only in pre-write or post-read
	assign waitrequest = data_access
		&& !(write && state == ST_PRE_WRITE)
		&& !(read && state == ST_POST_READ);
	assign host_wr = write && !waitrequest;
	assign launch = (state == ST_PRE_WRITE) || (state == ST_PRE_READ);
	assign irq = irq_en && !busy && init_done;

	always_comb
	begin
		state_nx = ST_IDLE;
		case (state)
			ST_IDLE:
			begin
				// Hold off until auto-init is over and the bus is free
				if (data_access && init_done && !busy)
				begin
					if (write)
						state_nx = ST_PRE_WRITE;
					else
						state_nx = dev_sel ? ST_PRE_READ : ST_POST_READ;
				end
			end
			ST_PRE_WRITE:      state_nx = ST_WRITE_TRANSFER;
			ST_WRITE_TRANSFER: state_nx = transfer_complete ? ST_POST_WRITE : state;
			ST_PRE_READ:       state_nx = ST_READ_TRANSFER;
			ST_READ_TRANSFER:  state_nx = transfer_complete ? ST_POST_READ : state;
			default:           state_nx = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (internal_reset)
		begin
			state          <= ST_IDLE;
			start_transfer <= 1'b0;
			irq_en         <= 1'b0;
			dev_sel        <= 1'b0;
			address_reg    <= '0;
			data_reg       <= '0;
		end
		else
		begin
			state          <= state_nx;
			// One cycle pulse on entry to the transfer state
			start_transfer <= launch;
			if (host_wr && address == REG_CONTROL && byteenable[0])
				irq_en <= writedata[1];
			if (host_wr && address == REG_CONTROL && byteenable[2])
				dev_sel <= writedata[16];
			if (host_wr && address == REG_ADDRESS && byteenable[0])
				address_reg <= writedata[7:0];
			for (int b = 0; b < 4; b++)
			begin
				if (host_wr && address == REG_DATA && byteenable[b])
					data_reg[b*8 +: 8] <= writedata[b*8 +: 8];
			end
		end
	end

	// Target of the transfer, frozen at launch
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			xfer_dev      <= dev_sel;
			xfer_addr     <= address_reg;
			read_transfer <= (state == ST_PRE_READ);
		end
	end

	always_ff @(posedge clk)
	begin
		if (read && !waitrequest)
		begin
			case (address)
				REG_CONTROL: readdata <= {15'h0, dev_sel, 14'h0, irq_en, 1'b0};
				REG_STATUS:  readdata <= {8'h00, CFG_TYPE, 7'h00, init_done && !init_error,
					6'h00, !busy && init_done, nack};
				REG_ADDRESS: readdata <= {24'h0, address_reg};
				default:     readdata <= dev_sel ? {24'h0, rx_data} : {23'h0, data_reg[8:0]};
			endcase
		end
	end

	always_comb
	begin
		frame = '0;
		if (!xfer_dev)
		begin
			frame.codec.dev_addr = AUDIO_DEV_ADDR;
			frame.codec.reg_addr = xfer_addr[6:0];
			frame.codec.data_hi  = data_reg[8];
			frame.codec.data_lo  = data_reg[7:0];
		end
		else
		begin
			frame.video.dev_addr  = VIDEO_DEV_WR_ADDR;
			frame.video.reg_addr  = xfer_addr;
			frame.video.data      = data_reg[7:0];
		end
		// Ones release the line, the decoder fills the byte
		restart_frame.video = '{VIDEO_DEV_RD_ADDR, 1'b1, 8'hFF, 1'b1, 8'hFF, 1'b1};
	end

	// Launch only waits on the controller, never overlaps it
	start_when_free: assert property (@(posedge clk) disable iff (internal_reset)
		start_transfer |-> !busy);

endmodule

`default_nettype wire

// File: design/av_config_top.sv
////////////////////////////////////////////////////////////
// Configuration subsystem top. The auto-init table owns the
// bus until init_done; sda is split into enable and sample
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module av_config_top (
	input  logic        clk,
	input  logic        internal_reset,
	input  logic [1:0]  address,
	input  logic [3:0]  byteenable,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	output logic [31:0] readdata,
	output logic        waitrequest,
	output logic        irq,
	output logic        scl,
	output logic        sda_drive_low,
	input  logic        sda_in
);
	import av_config_pkg::*;

	av_frame_u               rom_frame;
	av_frame_u               init_frame;
	av_frame_u               regs_frame;
	av_frame_u               restart_frame;
	av_frame_u               ctrl_frame;
	logic [INIT_IDX_W-1:0]   rom_index;
	logic                    init_start;
	logic                    init_done;
	logic                    init_error;
	logic                    regs_start;
	logic                    regs_read;
	logic                    ctrl_start;
	logic                    ctrl_read;
	logic                    busy;
	logic                    transfer_complete;
	logic                    nack;
	logic [7:0]              rx_data;

	// Frame source switches to the host once the table is done
	assign ctrl_frame = init_done ? regs_frame : init_frame;
	assign ctrl_start = init_done ? regs_start : init_start;
	assign ctrl_read  = init_done && regs_read;

	av_config_auto_init i_auto_init (
		.clk               (clk),
		.internal_reset    (internal_reset),
		.transfer_complete (transfer_complete),
		.nack              (nack),
		.rom_frame         (rom_frame),
		.rom_index         (rom_index),
		.init_frame        (init_frame),
		.init_start        (init_start),
		.init_done         (init_done),
		.init_error        (init_error)
	);

	av_config_init_rom i_init_rom (
		.rom_index (rom_index),
		.rom_frame (rom_frame)
	);

	av_config_regs i_regs (
		.clk               (clk),
		.internal_reset    (internal_reset),
		.address           (address),
		.byteenable        (byteenable),
		.read              (read),
		.write             (write),
		.writedata         (writedata),
		.readdata          (readdata),
		.waitrequest       (waitrequest),
		.init_done         (init_done),
		.init_error        (init_error),
		.busy              (busy),
		.transfer_complete (transfer_complete),
		.nack              (nack),
		.rx_data           (rx_data),
		.start_transfer    (regs_start),
		.read_transfer     (regs_read),
		.frame             (regs_frame),
		.restart_frame     (restart_frame),
		.irq               (irq)
	);

	serial_bus_controller i_serial (
		.clk               (clk),
		.internal_reset    (internal_reset),
		.start_transfer    (ctrl_start),
		.read_transfer     (ctrl_read),
		.frame             (ctrl_frame),
		.restart_frame     (restart_frame),
		.busy              (busy),
		.transfer_complete (transfer_complete),
		.scl               (scl),
		.sda_drive_low     (sda_drive_low),
		.sda_in            (sda_in),
		.rx_data           (rx_data),
		.nack              (nack)
	);

endmodule

`default_nettype wire

// File: tests/serial_device_model.sv
////////////////////////////////////////////////////////////
// Behavioral two-wire device. Acks every ack slot unless
// nack_mode is set; a frame with address bit 0 set is a read
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module serial_device_model (
	input  logic scl,
	input  logic sda,
	output logic sda_pull_low
);
	logic [26:0] frames [$];
	logic        nack_mode;
	logic [7:0]  read_byte;
	logic        active;
	int          cnt;
	logic [26:0] shift;
	logic [7:0]  dev_byte;

	initial
	begin
		sda_pull_low = 1'b0;
		nack_mode    = 1'b0;
		read_byte    = 8'h00;
		active       = 1'b0;
		cnt          = 0;
		shift        = '0;
		dev_byte     = 8'h00;
	end

	// Start or repeated start
	always @(negedge sda)
	begin
		if (scl)
		begin
			active = 1'b1;
			cnt    = 0;
			shift  = '0;
		end
	end

	// Stop
	always @(posedge sda)
	begin
		if (scl)
			active = 1'b0;
	end

	always @(posedge scl)
	begin
		if (active && cnt < 27)
		begin
			shift = {shift[25:0], sda};
			cnt   = cnt + 1;
			if (cnt == 8)
				dev_byte = shift[7:0];
			if (cnt == 27)
				frames.push_back(shift);
		end
	end

	// Next bit is set up while scl is low
	always @(negedge scl)
	begin
		sda_pull_low = 1'b0;
		if (active)
		begin
			if (cnt == 8)
				sda_pull_low = !nack_mode;
			else if (dev_byte[0] && cnt >= 9 && cnt <= 16)
				sda_pull_low = !read_byte[16 - cnt];
			else if (!dev_byte[0] && (cnt == 17 || cnt == 26))
				sda_pull_low = !nack_mode;
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_av_config.sv
////////////////////////////////////////////////////////////
// Directed tests for the configuration subsystem. The open
// drain sda wire is modelled here from both pull-downs
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_av_config;
	import av_config_pkg::*;

	logic        clk;
	logic        internal_reset;
	logic [1:0]  address;
	logic [3:0]  byteenable;
	logic        read;
	logic        write;
	logic [31:0] writedata;
	logic [31:0] readdata;
	logic        waitrequest;
	logic        irq;
	logic        scl;
	logic        sda_drive_low;
	logic        dev_pull_low;
	logic        sda_line;
	int          errors;
	int          tests_ok;
	int          tests_bad;
	int          wait_cycles;

	// Wired AND of both drivers
	assign sda_line = !(sda_drive_low || dev_pull_low);

	av_config_top i_av_config_top (
		.clk            (clk),
		.internal_reset (internal_reset),
		.address        (address),
		.byteenable     (byteenable),
		.read           (read),
		.write          (write),
		.writedata      (writedata),
		.readdata       (readdata),
		.waitrequest    (waitrequest),
		.irq            (irq),
		.scl            (scl),
		.sda_drive_low  (sda_drive_low),
		.sda_in         (sda_line)
	);

	serial_device_model i_device (
		.scl          (scl),
		.sda          (sda_line),
		.sda_pull_low (dev_pull_low)
	);

	always #50 clk = ~clk;

	task automatic compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Sampled at negedge, away from the drive edge
	task automatic wait_access();
		int n;
		n = 0;
		@(negedge clk);
		while (waitrequest && n < 2000)
		begin
			n++;
			@(negedge clk);
		end
		wait_cycles = n;
		assert (!waitrequest)
		else
		begin
			$display("Host access timed out, waitrequest stayed high");
			errors++;
		end
	endtask

	task automatic host_write(input logic [1:0] a, input logic [3:0] be, input logic [31:0] d);
		@(posedge clk);
		address    <= a;
		byteenable <= be;
		writedata  <= d;
		write      <= 1'b1;
		wait_access();
		@(posedge clk);
		write <= 1'b0;
	endtask

	task automatic host_read(input logic [1:0] a, output logic [31:0] d);
		@(posedge clk);
		address    <= a;
		byteenable <= 4'hF;
		read       <= 1'b1;
		wait_access();
		@(posedge clk);
		read <= 1'b0;
		@(negedge clk);
		d = readdata;
	endtask

	// Polls status until ready, busy needs two cycles to rise
	task automatic wait_ready(input int limit, output logic [31:0] s);
		int n;
		n = 0;
		repeat (4) @(posedge clk);
		host_read(REG_STATUS, s);
		while (!s[1] && n < limit)
		begin
			n++;
			repeat (8) @(posedge clk);
			host_read(REG_STATUS, s);
		end
		assert (s[1])
		else
		begin
			$display("Status never showed ready");
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - start_errors);
		end
	endtask

	function automatic logic [8:0] init_setting(input int i);
		case (i)
			0:       return AUD_LINE_IN_LC;
			1:       return AUD_LINE_IN_RC;
			2:       return AUD_LINE_OUT_LC;
			3:       return AUD_LINE_OUT_RC;
			4:       return AUD_ADC_PATH;
			5:       return AUD_DAC_PATH;
			6:       return AUD_POWER;
			7:       return AUD_DATA_FORMAT;
			8:       return AUD_SAMPLE_CTRL;
			default: return AUD_SET_ACTIVE;
		endcase
	endfunction

	// Acked codec frame as the device sees it
	function automatic logic [26:0] codec_frame(input logic [6:0] r, input logic [8:0] d);
		av_frame_u f;
		f = '0;
		f.codec.dev_addr = AUDIO_DEV_ADDR;
		f.codec.reg_addr = r;
		f.codec.data_hi  = d[8];
		f.codec.data_lo  = d[7:0];
		return f;
	endfunction

	task automatic test_auto_init();
		int e0;
		logic [31:0] s;
		e0 = errors;
		wait_ready(1000, s);
		compare_hex("frame_count", 32'(i_device.frames.size()), 32'(INIT_COUNT));
		for (int i = 0; i < INIT_COUNT && i < i_device.frames.size(); i++)
			compare_hex("init_frame", 32'(i_device.frames[i]),
				32'(codec_frame(7'(i), init_setting(i))));
		compare_hex("status_init_ok", 32'(s[8]), 32'h1);
		finish_test("auto-init", e0);
	endtask

	task automatic test_registers();
		int e0;
		logic [3:0] be;
		logic [31:0] d;
		logic [31:0] s;
		logic exp_irq_en;
		logic exp_dev;
		logic [7:0] exp_addr;
		e0 = errors;
		exp_irq_en = 1'b0;
		exp_dev = 1'b0;
		exp_addr = 8'h00;
		host_write(REG_CONTROL, 4'hF, 32'h0);
		host_write(REG_ADDRESS, 4'hF, 32'h0);
		for (int i = 0; i < 8; i++)
		begin
			be = 4'($urandom);
			d  = $urandom;
			if (($urandom & 1) == 1)
			begin
				host_write(REG_CONTROL, be, d);
				if (be[0])
					exp_irq_en = d[1];
				if (be[2])
					exp_dev = d[16];
			end
			else
			begin
				host_write(REG_ADDRESS, be, d);
				if (be[0])
					exp_addr = d[7:0];
			end
			host_read(REG_CONTROL, s);
			compare_hex("control", s, {15'h0, exp_dev, 14'h0, exp_irq_en, 1'b0});
			host_read(REG_ADDRESS, s);
			compare_hex("address", s, {24'h0, exp_addr});
		end
		host_read(REG_STATUS, s);
		compare_hex("cfg_type", 32'(s[23:16]), 32'(CFG_TYPE));
		host_write(REG_CONTROL, 4'hF, 32'h0);
		finish_test("registers", e0);
	endtask

	task automatic test_codec_write();
		int e0;
		int n0;
		logic [6:0] r;
		logic [8:0] d;
		logic [31:0] s;
		e0 = errors;
		r = 7'($urandom);
		d = 9'($urandom);
		host_write(REG_ADDRESS, 4'h1, {25'h0, r});
		n0 = i_device.frames.size();
		host_write(REG_DATA, 4'hF, {23'h0, d});
		// Launch holds the write for a single cycle
		compare_hex("write_wait", 32'(wait_cycles), 32'h1);
		wait_ready(300, s);
		compare_hex("frame_count", 32'(i_device.frames.size() - n0), 32'h1);
		if (i_device.frames.size() > n0)
			compare_hex("codec_frame", 32'(i_device.frames[n0]), 32'(codec_frame(r, d)));
		host_read(REG_DATA, s);
		compare_hex("read_wait", 32'(wait_cycles), 32'h1);
		compare_hex("data", s, {23'h0, d});
		host_read(REG_STATUS, s);
		compare_hex("status_nack", 32'(s[0]), 32'h0);
		finish_test("codec write", e0);
	endtask

	task automatic test_video_read();
		int e0;
		int n0;
		logic [7:0] r;
		logic [31:0] s;
		e0 = errors;
		r = 8'($urandom);
		i_device.read_byte = 8'($urandom);
		host_write(REG_CONTROL, 4'h4, 32'h0001_0000);
		host_write(REG_ADDRESS, 4'h1, {24'h0, r});
		n0 = i_device.frames.size();
		host_read(REG_DATA, s);
		compare_hex("readdata", s, {24'h0, i_device.read_byte});
		compare_hex("frame_count", 32'(i_device.frames.size() - n0), 32'h2);
		if (i_device.frames.size() >= n0 + 2)
		begin
			compare_hex("wr_dev", 32'(i_device.frames[n0][26:19]), 32'(VIDEO_DEV_WR_ADDR));
			compare_hex("wr_reg", 32'(i_device.frames[n0][17:10]), 32'(r));
			compare_hex("rd_dev", 32'(i_device.frames[n0+1][26:19]), 32'(VIDEO_DEV_RD_ADDR));
		end
		host_write(REG_CONTROL, 4'h4, 32'h0);
		finish_test("video read", e0);
	endtask

	task automatic test_nack();
		int e0;
		logic [31:0] s;
		e0 = errors;
		i_device.nack_mode = 1'b1;
		host_write(REG_DATA, 4'hF, $urandom & 32'h1FF);
		wait_ready(300, s);
		compare_hex("status_nack", 32'(s[0]), 32'h1);
		i_device.nack_mode = 1'b0;
		host_write(REG_DATA, 4'hF, $urandom & 32'h1FF);
		wait_ready(300, s);
		compare_hex("status_nack", 32'(s[0]), 32'h0);
		finish_test("nack", e0);
	endtask

	task automatic test_irq();
		int e0;
		logic [31:0] s;
		e0 = errors;
		host_write(REG_CONTROL, 4'h1, 32'h2);
		@(negedge clk);
		compare_hex("irq_idle", 32'(irq), 32'h1);
		host_write(REG_DATA, 4'hF, $urandom & 32'h1FF);
		// Busy follows the accepted write by two cycles
		repeat (3) @(negedge clk);
		compare_hex("irq_busy", 32'(irq), 32'h0);
		wait_ready(300, s);
		@(negedge clk);
		compare_hex("irq_done", 32'(irq), 32'h1);
		host_write(REG_CONTROL, 4'h1, 32'h0);
		finish_test("irq", e0);
	endtask

	// Longest run is bounded by init plus a dozen transfers
	initial
	begin
		#((INIT_COUNT + 12) * 900 * 100);
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hb5614588));
		clk            = 1'b0;
		internal_reset = 1'b1;
		address        = 2'd0;
		byteenable     = 4'h0;
		read           = 1'b0;
		write          = 1'b0;
		writedata      = 32'h0;
		errors         = 0;
		tests_ok       = 0;
		tests_bad      = 0;
		wait_cycles    = 0;
		repeat (10) @(posedge clk);
		internal_reset <= 1'b0;
		test_auto_init();
		test_registers();
		test_codec_write();
		test_video_read();
		test_nack();
		test_irq();
		$display("Summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/av_config_pkg.sv
design/av_config_init_rom.sv
design/av_config_auto_init.sv
design/serial_bus_controller.sv
design/av_config_regs.sv
design/av_config_top.sv
tests/serial_device_model.sv
tests/tb_av_config.sv

// File: run_sim.sh
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_av_config \
	-o Vtb_av_config
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/Vtb_av_config > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
